// File: project.f
design/mem_stage_pkg.sv
design/store_lane_encoder.sv
design/mem_access_arbiter.sv
design/data_memory.sv
design/dirty_bit_tracker.sv
design/load_align_writeback.sv
design/mem_stage_top.sv
verification/mem_stage_asserts.sv
verification/tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mem_stage -f project.f -o sim_mem_stage
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/sim_mem_stage)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

// File: verification/tb_mem_stage.sv
`timescale 1ns/100ps

module tb_mem_stage;

   logic                                  i_clock;
   logic                                  i_soft_reset;
   mem_stage_pkg::mem_req_t               i_mem_req;
   logic                                  i_dbg_read;
   logic [mem_stage_pkg::WORD_ADDR_W-1:0] i_dbg_addr;
   mem_stage_pkg::wb_t                    o_wb;
   mem_stage_pkg::dbg_rsp_t               o_dbg_rsp;
   logic                                  o_soft_reset_ack;

   logic [7:0]              ref_mem [1024];
   logic                    ref_dirty [256];
   mem_stage_pkg::wb_t      exp_wb_q [$];
   bit                      exp_has_data_q [$];
   logic [9:0]              used_addr [20];
   int                      seed;
   int                      errors;
   int                      checks;
   int                      cycles;

   mem_stage_top u_mem_stage_top (.*);

   initial begin
      i_clock = 1'b0;
      forever #4 i_clock = ~i_clock;
   end

   // Run limit covers two clears and every operation with margin.
   always @(posedge i_clock) begin
      cycles++;
      if (cycles >= 3000) begin
         $display("Timeout: the run did not finish within 3000 cycles");
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic note_error(input string msg);
      errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   ////////////////////////////////////////
   // Reference model.
   ////////////////////////////////////////
   function automatic logic [31:0] expected_load(input mem_stage_pkg::mem_op_e op,
                                                 input logic [9:0] a);
      logic [7:0]  b;
      logic [15:0] h;
      b = ref_mem[a];
      h = {ref_mem[{a[9:1], 1'b1}], ref_mem[{a[9:1], 1'b0}]};
      case (op)
         mem_stage_pkg::MEM_BYTE:   return {{24{b[7]}}, b};
         mem_stage_pkg::MEM_BYTE_U: return {24'h0, b};
         mem_stage_pkg::MEM_HALF:   return {{16{h[15]}}, h};
         mem_stage_pkg::MEM_HALF_U: return {16'h0, h};
         default: return {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                          ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
      endcase
   endfunction

   task automatic model_store(input mem_stage_pkg::mem_op_e op, input logic [9:0] a,
                              input logic [31:0] d);
      if (op == mem_stage_pkg::MEM_BYTE) begin
         ref_mem[a] = d[7:0];
      end else if (op == mem_stage_pkg::MEM_HALF) begin
         ref_mem[{a[9:1], 1'b0}] = d[7:0];
         ref_mem[{a[9:1], 1'b1}] = d[15:8];
      end else begin
         for (int i = 0; i < 4; i++) ref_mem[{a[9:2], 2'(i)}] = d[8*i +: 8];
      end
      ref_dirty[a[9:2]] = 1'b1;
   endtask

   function automatic mem_stage_pkg::mem_req_t make_req(input mem_stage_pkg::mem_op_e op,
         input logic wr, input logic [9:0] a, input logic [31:0] d);
      mem_stage_pkg::mem_req_t r;
      r = '0;
      r.valid      = 1'b1;
      r.mem_read   = ~wr;
      r.mem_write  = wr;
      r.op         = op;
      r.addr       = a;
      r.wdata      = d;
      r.rd_idx     = 5'($random(seed));
      r.reg_write  = 1'($random(seed));
      r.mem_to_reg = 1'($random(seed));
      r.halt       = 1'($random(seed));
      r.alu_result = $random(seed);
      return r;
   endfunction

   ////////////////////////////////////////
   // Stimulus tasks.
   ////////////////////////////////////////
   task automatic issue(input mem_stage_pkg::mem_req_t r, input logic dbg);
      mem_stage_pkg::wb_t e;
      e = '0;
      e.valid      = 1'b1;
      e.reg_write  = r.reg_write;
      e.mem_to_reg = r.mem_to_reg;
      e.rd_idx     = r.rd_idx;
      e.halt       = r.halt;
      e.alu_data   = r.alu_result;
      if (r.mem_read) e.mem_data = expected_load(r.op, r.addr);
      exp_wb_q.push_back(e);
      exp_has_data_q.push_back(r.mem_read);
      if (r.mem_write) model_store(r.op, r.addr, r.wdata);
      @(posedge i_clock);
      i_mem_req  <= r;
      i_dbg_read <= dbg;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge i_clock);
         i_mem_req  <= '0;
         i_dbg_read <= 1'b0;
      end
   endtask

   task automatic wait_dbg_rsp(input logic [31:0] exp_data, input logic exp_dirty);
      int n;
      n = 0;
      @(negedge i_clock);
      while (!o_dbg_rsp.valid && n < 20) begin
         @(negedge i_clock);
         n++;
      end
      checks++;
      if (!o_dbg_rsp.valid) note_error("debug response never arrived");
      else assert (o_dbg_rsp.data == exp_data && o_dbg_rsp.dirty == exp_dirty)
         else note_error($sformatf("debug got %h/%b expected %h/%b", o_dbg_rsp.data,
                                   o_dbg_rsp.dirty, exp_data, exp_dirty));
   endtask

   task automatic dbg_check(input logic [7:0] w);
      @(posedge i_clock);
      i_mem_req  <= '0;
      i_dbg_read <= 1'b1;
      i_dbg_addr <= w;
      idle(1);
      wait_dbg_rsp(expected_load(mem_stage_pkg::MEM_WORD, {w, 2'b00}), ref_dirty[w]);
   endtask

   task automatic reset_dut();
      int n;
      i_soft_reset <= 1'b0;
      repeat (3) @(posedge i_clock);
      i_soft_reset <= 1'b1;
      for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h0;
      for (int i = 0; i < 256; i++) ref_dirty[i] = 1'b0;
      n = 0;
      @(negedge i_clock);
      while (!o_soft_reset_ack && n < 400) begin
         @(negedge i_clock);
         n++;
      end
      if (!o_soft_reset_ack) note_error("acknowledge never rose after reset");
   endtask

   // Write-back checks on the falling edge.
   always @(negedge i_clock) begin
      mem_stage_pkg::wb_t e;
      bit has_data;
      if (i_soft_reset && o_wb.valid) begin
         checks++;
         if (exp_wb_q.size() == 0) begin
            note_error("write-back appeared with nothing expected");
         end else begin
            e = exp_wb_q.pop_front();
            has_data = exp_has_data_q.pop_front();
            assert (o_wb.rd_idx == e.rd_idx && o_wb.reg_write == e.reg_write &&
                    o_wb.mem_to_reg == e.mem_to_reg && o_wb.halt == e.halt &&
                    o_wb.alu_data == e.alu_data)
               else note_error("write-back control fields differ");
            if (has_data) assert (o_wb.mem_data == e.mem_data)
               else note_error($sformatf("load got %h expected %h", o_wb.mem_data, e.mem_data));
         end
      end
   end

   initial begin
      logic [9:0] a;
      i_soft_reset = 1'b0;
      i_mem_req    = '0;
      i_dbg_read   = 1'b0;
      i_dbg_addr   = '0;
      seed   = 32'hc562_5915;
      errors = 0;
      checks = 0;
      cycles = 0;

      // Clear and acknowledge.
      reset_dut();
      repeat (8) dbg_check(8'($random(seed)));

      // Back-to-back word stores followed by word loads.
      for (int i = 0; i < 20; i++) begin
         used_addr[i] = 10'($random(seed));
         issue(make_req(mem_stage_pkg::MEM_WORD, 1'b1, used_addr[i], $random(seed)), 1'b0);
      end
      for (int i = 0; i < 20; i++)
         issue(make_req(mem_stage_pkg::MEM_WORD, 1'b0, used_addr[i], 0), 1'b0);

      // Byte and halfword stores at every offset with a word load after each.
      for (int i = 0; i < 12; i++) begin
         a = 10'($random(seed));
         for (int off = 0; off < 4; off++) begin
            issue(make_req(mem_stage_pkg::MEM_BYTE, 1'b1, {a[9:2], 2'(off)}, $random(seed)), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_WORD, 1'b0, a, 0), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_HALF, 1'b1, {a[9:2], 2'(off)}, $random(seed)), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_WORD, 1'b0, a, 0), 1'b0);
         end
      end

      // Sub-word loads right after a word store to the same word.
      for (int i = 0; i < 8; i++) begin
         a = 10'($random(seed));
         issue(make_req(mem_stage_pkg::MEM_WORD, 1'b1, a, $random(seed)), 1'b0);
         for (int off = 0; off < 4; off++) begin
            issue(make_req(mem_stage_pkg::MEM_BYTE, 1'b0, {a[9:2], 2'(off)}, 0), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_BYTE_U, 1'b0, {a[9:2], 2'(off)}, 0), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_HALF, 1'b0, {a[9:2], 2'(off)}, 0), 1'b0);
            issue(make_req(mem_stage_pkg::MEM_HALF_U, 1'b0, {a[9:2], 2'(off)}, 0), 1'b0);
         end
      end
      idle(3);

      // Dirty bits and a debug read that collides with pipeline traffic.
      for (int i = 0; i < 20; i++) dbg_check(used_addr[i][9:2]);
      repeat (10) dbg_check(8'($random(seed)));
      a = used_addr[3];
      @(posedge i_clock);
      i_dbg_addr <= a[9:2];
      issue(make_req(mem_stage_pkg::MEM_WORD, 1'b1, a, $random(seed)), 1'b1);
      repeat (3) issue(make_req(mem_stage_pkg::MEM_WORD, 1'b0, a, 0), 1'b0);
      idle(1);
      wait_dbg_rsp(expected_load(mem_stage_pkg::MEM_WORD, a), 1'b1);

      // Second reset clears the data and the dirty bits.
      idle(4);
      reset_dut();
      for (int i = 0; i < 20; i++) dbg_check(used_addr[i][9:2]);
      idle(4);

      if (exp_wb_q.size() != 0) note_error("expected write-backs never arrived");
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) $display("ALL TESTS PASSED");
      else $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: verification/mem_stage_asserts.sv
`timescale 1ns/100ps

module mem_stage_asserts (
   input                            i_clock,
   input                            i_soft_reset,
   input mem_stage_pkg::mem_req_t   i_mem_req,
   input                            i_dbg_read,
   input mem_stage_pkg::wb_t        o_wb,
   input mem_stage_pkg::dbg_rsp_t   o_dbg_rsp,
   input                            o_soft_reset_ack
);

   int dbg_outstanding;

   // Debug reads issued but not yet answered.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) dbg_outstanding <= 0;
      else dbg_outstanding <= dbg_outstanding + int'(i_dbg_read) - int'(o_dbg_rsp.valid);
   end

   a_reset_quiet: assert property (@(posedge i_clock)
      !i_soft_reset |=> !o_wb.valid && !o_dbg_rsp.valid && !o_soft_reset_ack)
      else $error("outputs not quiet after reset");

   a_wb_latency: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_mem_req.valid |-> ##2 o_wb.valid)
      else $error("write-back missing two edges after request");

   a_wb_cause: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_wb.valid |-> $past(i_mem_req.valid, 2))
      else $error("write-back without a request two edges earlier");

   a_ack_holds: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_soft_reset_ack |=> o_soft_reset_ack)
      else $error("acknowledge fell while out of reset");

   a_dbg_cause: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_dbg_rsp.valid |-> dbg_outstanding > 0)
      else $error("debug response without a debug read");

endmodule

bind mem_stage_top mem_stage_asserts u_mem_stage_asserts (.*);

// File: design/mem_stage_top.sv
`timescale 1ns/100ps

module mem_stage_top (
   input                                   i_clock,
   input                                   i_soft_reset,
   input  mem_stage_pkg::mem_req_t         i_mem_req,
   input                                   i_dbg_read,
   input  [mem_stage_pkg::WORD_ADDR_W-1:0] i_dbg_addr,
   output mem_stage_pkg::wb_t              o_wb,
   output mem_stage_pkg::dbg_rsp_t         o_dbg_rsp,
   output                                  o_soft_reset_ack
);

   mem_stage_pkg::ram_port_t          pipe_port;
   mem_stage_pkg::req_tag_t           pipe_tag;
   mem_stage_pkg::ram_port_t          ram_port;
   mem_stage_pkg::req_tag_t           flight_tag;
   logic [mem_stage_pkg::DATA_W-1:0]  ram_rdata;
   logic                              word_dirty;

   ////////////////////////////////////////
   // Request side.
   ////////////////////////////////////////
   store_lane_encoder u_store_lane_encoder (
      .i_mem_req  (i_mem_req),
      .o_ram_port (pipe_port),
      .o_tag      (pipe_tag)
   );

   // The acknowledge also holds off grants during the clear.
   mem_access_arbiter u_mem_access_arbiter (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_soft_reset_ack (o_soft_reset_ack),
      .i_pipe_port      (pipe_port),
      .i_pipe_tag       (pipe_tag),
      .i_pipe_valid     (i_mem_req.valid),
      .i_dbg_read       (i_dbg_read),
      .i_dbg_addr       (i_dbg_addr),
      .o_ram_port       (ram_port),
      .o_tag            (flight_tag)
   );

   ////////////////////////////////////////
   // Storage.
   ////////////////////////////////////////
   data_memory u_data_memory (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_ram_port       (ram_port),
      .o_rdata          (ram_rdata),
      .o_soft_reset_ack (o_soft_reset_ack)
   );

   dirty_bit_tracker u_dirty_bit_tracker (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_ram_port   (ram_port),
      .o_dirty      (word_dirty)
   );

   // Write-back and debug responses.
   load_align_writeback u_load_align_writeback (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_tag        (flight_tag),
      .i_rdata      (ram_rdata),
      .i_dirty      (word_dirty),
      .o_wb         (o_wb),
      .o_dbg_rsp    (o_dbg_rsp)
   );

endmodule

// File: design/load_align_writeback.sv
`timescale 1ns/100ps

module load_align_writeback (
   input                                    i_clock,
   input                                    i_soft_reset,
   input  mem_stage_pkg::req_tag_t          i_tag,
   input  [mem_stage_pkg::DATA_W-1:0]       i_rdata,
   input                                    i_dirty,
   output mem_stage_pkg::wb_t               o_wb,
   output mem_stage_pkg::dbg_rsp_t          o_dbg_rsp
);

   localparam int HALF_W = 2 * mem_stage_pkg::LANE_W;

   logic [mem_stage_pkg::LANE_W-1:0]  sel_byte;
   logic [HALF_W-1:0]                 sel_half;
   logic [mem_stage_pkg::DATA_W-1:0]  load_data;

   assign sel_byte = i_rdata[i_tag.offset * mem_stage_pkg::LANE_W +: mem_stage_pkg::LANE_W];
   assign sel_half = i_rdata[i_tag.offset[mem_stage_pkg::LANE_SEL_W-1] * HALF_W +: HALF_W];

   // Extend by op.
   always_comb begin
      case (i_tag.op)
         mem_stage_pkg::MEM_BYTE:
            load_data = {{(mem_stage_pkg::DATA_W - mem_stage_pkg::LANE_W){sel_byte[mem_stage_pkg::LANE_W-1]}},
                         sel_byte};
         mem_stage_pkg::MEM_BYTE_U:
            load_data = {{(mem_stage_pkg::DATA_W - mem_stage_pkg::LANE_W){1'b0}}, sel_byte};
         mem_stage_pkg::MEM_HALF:
            load_data = {{(mem_stage_pkg::DATA_W - HALF_W){sel_half[HALF_W-1]}}, sel_half};
         mem_stage_pkg::MEM_HALF_U:
            load_data = {{(mem_stage_pkg::DATA_W - HALF_W){1'b0}}, sel_half};
         default:
            load_data = i_rdata;
      endcase
   end

   ////////////////////////////////////////
   // Response registers.
   ////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_wb      <= '0;
         o_dbg_rsp <= '0;
      end else begin
         o_wb.valid      <= (i_tag.owner == mem_stage_pkg::OWNER_PIPE);
         o_dbg_rsp.valid <= (i_tag.owner == mem_stage_pkg::OWNER_DBG);
         if (i_tag.owner == mem_stage_pkg::OWNER_PIPE) begin
            o_wb.reg_write  <= i_tag.reg_write;
            o_wb.mem_to_reg <= i_tag.mem_to_reg;
            o_wb.rd_idx     <= i_tag.rd_idx;
            o_wb.halt       <= i_tag.halt;
            o_wb.alu_data   <= i_tag.alu_data;
            o_wb.mem_data   <= load_data;
         end
         if (i_tag.owner == mem_stage_pkg::OWNER_DBG) begin
            o_dbg_rsp.data  <= i_rdata;
            o_dbg_rsp.dirty <= i_dirty;
         end
      end
   end

endmodule

// File: design/dirty_bit_tracker.sv
`timescale 1ns/100ps

module dirty_bit_tracker (
   input                            i_clock,
   input                            i_soft_reset,
   input  mem_stage_pkg::ram_port_t i_ram_port,
   output logic                     o_dirty
);

   logic [mem_stage_pkg::MEM_DEPTH-1:0] dirty_q;
   logic                                word_written;

   assign word_written = i_ram_port.en & (|i_ram_port.we);

   // One flag per word.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty_q <= '0;
      end else if (word_written) begin
         dirty_q[i_ram_port.addr] <= 1'b1;
      end
   end

   // Sampled with the RAM read so it lines up with o_rdata.
   always_ff @(posedge i_clock) begin
      if (i_ram_port.en) o_dirty <= dirty_q[i_ram_port.addr];
   end

endmodule

// File: design/data_memory.sv
`timescale 1ns/100ps

module data_memory (
   input                                   i_clock,
   input                                   i_soft_reset,
   input  mem_stage_pkg::ram_port_t        i_ram_port,
   output logic [mem_stage_pkg::DATA_W-1:0] o_rdata,
   output                                  o_soft_reset_ack
);

   typedef enum logic {CLEARING, READY} clear_state_e;

   clear_state_e                               state_q;
   logic [mem_stage_pkg::WORD_ADDR_W-1:0]      clr_cnt_q;
   logic [mem_stage_pkg::NUM_LANES-1:0]        wr_we;
   logic [mem_stage_pkg::WORD_ADDR_W-1:0]      wr_addr;
   logic [mem_stage_pkg::DATA_W-1:0]           wr_data;
   logic [mem_stage_pkg::NUM_LANES-1:0][mem_stage_pkg::LANE_W-1:0] mem_q [mem_stage_pkg::MEM_DEPTH];

   ////////////////////////////////////////
   // Clear sequencer.
   ////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state_q   <= CLEARING;
         clr_cnt_q <= '0;
      end else if (state_q == CLEARING) begin
         clr_cnt_q <= clr_cnt_q + 1'b1;
         if (clr_cnt_q == mem_stage_pkg::WORD_ADDR_W'(mem_stage_pkg::MEM_DEPTH - 1)) begin
            state_q <= READY;
         end
      end
   end

   assign o_soft_reset_ack = (state_q == READY);

   // The clear owns the write port until it is done.
   always_comb begin
      if (state_q == CLEARING) begin
         wr_we   = '1;
         wr_addr = clr_cnt_q;
         wr_data = '0;
      end else begin
         wr_we   = i_ram_port.en ? i_ram_port.we : '0;
         wr_addr = i_ram_port.addr;
         wr_data = i_ram_port.wdata;
      end
   end

   ////////////////////////////////////////
   // Byte-column array.
   ////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      for (int l = 0; l < mem_stage_pkg::NUM_LANES; l++) begin
         if (wr_we[l]) begin
            mem_q[wr_addr][l] <= wr_data[l*mem_stage_pkg::LANE_W +: mem_stage_pkg::LANE_W];
         end
      end
      if (i_ram_port.en) o_rdata <= mem_q[i_ram_port.addr];
   end

endmodule

// File: design/mem_access_arbiter.sv
`timescale 1ns/100ps

module mem_access_arbiter (
   input                                         i_clock,
   input                                         i_soft_reset,
   input                                         i_soft_reset_ack,
   input  mem_stage_pkg::ram_port_t              i_pipe_port,
   input  mem_stage_pkg::req_tag_t               i_pipe_tag,
   input                                         i_pipe_valid,
   input                                         i_dbg_read,
   input  [mem_stage_pkg::WORD_ADDR_W-1:0]       i_dbg_addr,
   output mem_stage_pkg::ram_port_t              o_ram_port,
   output mem_stage_pkg::req_tag_t               o_tag
);

   logic                                   dbg_pend_q;
   logic [mem_stage_pkg::WORD_ADDR_W-1:0]  dbg_addr_q;
   logic [mem_stage_pkg::WORD_ADDR_W-1:0]  dbg_addr;
   logic                                   dbg_req;
   logic                                   pipe_grant;
   logic                                   dbg_grant;

   // A fresh strobe is served right away when the pipeline is quiet.
   assign dbg_req    = i_dbg_read | dbg_pend_q;
   assign dbg_addr   = dbg_pend_q ? dbg_addr_q : i_dbg_addr;
   assign pipe_grant = i_soft_reset_ack & i_pipe_valid;
   assign dbg_grant  = i_soft_reset_ack & ~i_pipe_valid & dbg_req;

   always_comb begin
      o_ram_port = '0;
      if (pipe_grant) begin
         o_ram_port = i_pipe_port;
      end else if (dbg_grant) begin
         o_ram_port.en   = 1'b1;
         o_ram_port.addr = dbg_addr;
      end
   end

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dbg_pend_q <= 1'b0;
         o_tag      <= '0;
      end else begin
         if (dbg_grant) dbg_pend_q <= 1'b0;
         else if (i_dbg_read) dbg_pend_q <= 1'b1;

         // Idle cycles leave owner none so nothing is answered.
         if (pipe_grant) o_tag <= i_pipe_tag;
         else if (dbg_grant) o_tag.owner <= mem_stage_pkg::OWNER_DBG;
         else o_tag.owner <= mem_stage_pkg::OWNER_NONE;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_dbg_read) dbg_addr_q <= i_dbg_addr;
   end

endmodule

// File: design/store_lane_encoder.sv
`timescale 1ns/100ps

module store_lane_encoder (
   input  mem_stage_pkg::mem_req_t  i_mem_req,
   output mem_stage_pkg::ram_port_t o_ram_port,
   output mem_stage_pkg::req_tag_t  o_tag
);

   logic [mem_stage_pkg::LANE_SEL_W-1:0] offset;
   logic [mem_stage_pkg::NUM_LANES-1:0]  lanes;
   logic [mem_stage_pkg::DATA_W-1:0]     wdata_aligned;

   assign offset = i_mem_req.addr[mem_stage_pkg::LANE_SEL_W-1:0];

   // Lane pattern and replicated data by access size.
   // Halfwords ignore the low offset bit.
   always_comb begin
      case (i_mem_req.op)
         mem_stage_pkg::MEM_BYTE, mem_stage_pkg::MEM_BYTE_U: begin
            lanes = mem_stage_pkg::NUM_LANES'(1) << offset;
            wdata_aligned = {mem_stage_pkg::NUM_LANES{i_mem_req.wdata[7:0]}};
         end
         mem_stage_pkg::MEM_HALF, mem_stage_pkg::MEM_HALF_U: begin
            lanes = mem_stage_pkg::NUM_LANES'(3) << {offset[mem_stage_pkg::LANE_SEL_W-1], 1'b0};
            wdata_aligned = {(mem_stage_pkg::NUM_LANES / 2){i_mem_req.wdata[15:0]}};
         end
         default: begin
            lanes = '1;
            wdata_aligned = i_mem_req.wdata;
         end
      endcase
   end

   // Loads keep the port enabled with no lanes set.
   assign o_ram_port.en    = i_mem_req.valid & (i_mem_req.mem_read | i_mem_req.mem_write);
   assign o_ram_port.we    = i_mem_req.mem_write ? lanes : '0;
   assign o_ram_port.addr  = i_mem_req.addr[mem_stage_pkg::BYTE_ADDR_W-1:mem_stage_pkg::LANE_SEL_W];
   assign o_ram_port.wdata = wdata_aligned;

   assign o_tag.owner      = mem_stage_pkg::OWNER_PIPE;
   assign o_tag.op         = i_mem_req.op;
   assign o_tag.offset     = offset;
   assign o_tag.rd_idx     = i_mem_req.rd_idx;
   assign o_tag.reg_write  = i_mem_req.reg_write;
   assign o_tag.mem_to_reg = i_mem_req.mem_to_reg;
   assign o_tag.halt       = i_mem_req.halt;
   assign o_tag.alu_data   = i_mem_req.alu_result;

endmodule

// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

   ////////////////////////////////////////
   // Sizes.
   ////////////////////////////////////////
   localparam int DATA_W      = 32;
   localparam int NUM_LANES   = 4;
   localparam int MEM_DEPTH   = 256;
   localparam int WORD_ADDR_W = 8;
   localparam int BYTE_ADDR_W = 10;
   localparam int REG_IDX_W   = 5;
   // Derived lane width and lane select width.
   localparam int LANE_W      = DATA_W / NUM_LANES;
   localparam int LANE_SEL_W  = BYTE_ADDR_W - WORD_ADDR_W;

   ////////////////////////////////////////
   // Encodings.
   ////////////////////////////////////////
   typedef enum logic [2:0] {
      MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE_U, MEM_HALF_U
   } mem_op_e;

   // Who owns the access that is in flight.
   typedef enum logic [1:0] {
      OWNER_NONE, OWNER_PIPE, OWNER_DBG
   } owner_e;

   ////////////////////////////////////////
   // Bundles.
   ////////////////////////////////////////
   typedef struct packed {
      logic                   valid;
      logic                   mem_read;
      logic                   mem_write;
      mem_op_e                op;
      logic [BYTE_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
      logic [REG_IDX_W-1:0]   rd_idx;
      logic                   reg_write;
      logic                   mem_to_reg;
      logic                   halt;
      logic [DATA_W-1:0]      alu_result;
   } mem_req_t;

   typedef struct packed {
      logic                   en;
      logic [NUM_LANES-1:0]   we;
      logic [WORD_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
   } ram_port_t;

   typedef struct packed {
      owner_e                owner;
      mem_op_e               op;
      logic [LANE_SEL_W-1:0] offset;
      logic [REG_IDX_W-1:0]  rd_idx;
      logic                  reg_write;
      logic                  mem_to_reg;
      logic                  halt;
      logic [DATA_W-1:0]     alu_data;
   } req_tag_t;

   typedef struct packed {
      logic                 valid;
      logic                 reg_write;
      logic                 mem_to_reg;
      logic [REG_IDX_W-1:0] rd_idx;
      logic                 halt;
      logic [DATA_W-1:0]    alu_data;
      logic [DATA_W-1:0]    mem_data;
   } wb_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
      logic              dirty;
   } dbg_rsp_t;

endpackage
